/* Bender.yml */
package:
  name: wide_mul

sources:
  - files:
      - mul_geom_pkg.sv
      - mul_pipe_pkg.sv
      - partial_product_array.sv
      - row_accumulator.sv
      - reduction_tree.sv
      - wide_mul_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - wide_mul_tb.sv

/* list.f */
+incdir+.
mul_geom_pkg.sv
mul_pipe_pkg.sv
partial_product_array.sv
row_accumulator.sv
reduction_tree.sv
wide_mul_top.sv
wide_mul_tb.sv

/* mul_geom_pkg.sv */
package mul_geom_pkg;

        // operand side.
        localparam int OP_WIDTH = 256; // one full word per operand.

        // limb cut, x is coarse, y is fine.
        localparam int X_LIMB_W = 24; // maps onto a 24-bit multiplier port.
        localparam int Y_LIMB_W = 16; // the narrow multiplier port.

        // top x limb is only 16 bits wide and gets zero-extended.
        localparam int X_LIMBS = (OP_WIDTH + X_LIMB_W - 1) / X_LIMB_W; // 11.
        localparam int Y_LIMBS = (OP_WIDTH + Y_LIMB_W - 1) / Y_LIMB_W; // 16.

        // one registered limb product.
        localparam int PP_W = X_LIMB_W + Y_LIMB_W; // 40.

        // row = one x limb times all of y.
        // 280 bits are needed, the extra byte is headroom.
        localparam int ROW_GUARD = 8; // guard bits above the row sum.
        localparam int ROW_W = OP_WIDTH + X_LIMB_W + ROW_GUARD; // 288.

        // full double-width product.
        localparam int PROD_W = 2 * OP_WIDTH; // 512.

endpackage

/* mul_pipe_pkg.sv */
package mul_pipe_pkg;

        // limb products, one register stage.
        localparam int PP_STAGES = 1;

        // weighted row sums, one register stage.
        localparam int ROW_STAGES = 1;

        // pairwise adder levels needed to fold all rows into one.
        // each level halves the row count, rounding up.
        localparam int TREE_LEVELS = $clog2(mul_geom_pkg::X_LIMBS); // 4.

        // operand pair in to product out, in clocks.
        // fixed, no stalls, one new pair per clock.
        localparam int LATENCY = PP_STAGES + ROW_STAGES + TREE_LEVELS; // 6.

endpackage

/* partial_product_array.sv */
`timescale 1ns/1ps

module partial_product_array #(
        parameter int OP_WIDTH = mul_geom_pkg::OP_WIDTH, // operand width.
        parameter int X_LIMB_W = mul_geom_pkg::X_LIMB_W, // x limb width.
        parameter int Y_LIMB_W = mul_geom_pkg::Y_LIMB_W, // y limb width.
        localparam int X_LIMBS = (OP_WIDTH + X_LIMB_W - 1) / X_LIMB_W,
        localparam int Y_LIMBS = (OP_WIDTH + Y_LIMB_W - 1) / Y_LIMB_W,
        localparam int PP_W = X_LIMB_W + Y_LIMB_W
) (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic [OP_WIDTH-1:0]            x,  // multiplicand.
        input  logic [OP_WIDTH-1:0]            y,  // multiplier.
        output logic [X_LIMBS*Y_LIMBS*PP_W-1:0] pp // product (i,j) at slot i*Y_LIMBS+j.
);

        logic [X_LIMBS*X_LIMB_W-1:0] x_ext; // x padded to whole limbs.
        logic [Y_LIMBS*Y_LIMB_W-1:0] y_ext; // y padded to whole limbs.

        // upper pad bits come out zero, unsigned cast.
        assign x_ext = (X_LIMBS * X_LIMB_W)'(x);
        assign y_ext = (Y_LIMBS * Y_LIMB_W)'(y);

        // one multiplier per limb pair.
        for (genvar i = 0; i < X_LIMBS; i++) begin : g_x
                for (genvar j = 0; j < Y_LIMBS; j++) begin : g_y
                        localparam int SLOT = (i * Y_LIMBS + j) * PP_W; // flat offset.

                        logic [X_LIMB_W-1:0] x_limb;
                        logic [Y_LIMB_W-1:0] y_limb;
                        logic [PP_W-1:0]     prod_q; // registered limb product.

                        assign x_limb = x_ext[i*X_LIMB_W +: X_LIMB_W];
                        assign y_limb = y_ext[j*Y_LIMB_W +: Y_LIMB_W];

                        // product is sized by prod_q, no overflow possible.
                        always_ff @(posedge clk or negedge rst_n) begin
                                if (!rst_n) begin
                                        prod_q <= '0;
                                end else begin
                                        prod_q <= x_limb * y_limb; // 24x16 fits a dsp.
                                end
                        end

                        assign pp[SLOT +: PP_W] = prod_q;
                end
        end

endmodule

/* reduction_tree.sv */
`timescale 1ns/1ps

module reduction_tree #(
        parameter int N_ROWS = mul_geom_pkg::X_LIMBS,   // rows to fold.
        parameter int ROW_STEP = mul_geom_pkg::X_LIMB_W, // weight gap between rows.
        parameter int ROW_W = mul_geom_pkg::ROW_W,       // width of one row.
        parameter int PROD_W = mul_geom_pkg::PROD_W      // final product width.
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [N_ROWS*ROW_W-1:0] rows,   // row i at weight i*ROW_STEP.
        output logic [PROD_W-1:0]       product // sum of all weighted rows.
);

        // width at a level, one shift plus a carry per level, capped at PROD_W.
        function automatic int level_w(input int lvl);
                int w;
                w = ROW_W;
                for (int l = 0; l < lvl; l++) begin
                        w = w + (ROW_STEP << l) + 1;
                end
                return (w > PROD_W) ? PROD_W : w; // bits above PROD_W never matter.
        endfunction

        // operand count at a level, halved per level, rounded up.
        function automatic int level_n(input int lvl);
                int n;
                n = N_ROWS;
                for (int l = 0; l < lvl; l++) begin
                        n = (n + 1) / 2;
                end
                return n;
        endfunction

        localparam int LEVELS = $clog2(N_ROWS); // one register per level.

        for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
                localparam int IN_W = level_w(l);
                localparam int OUT_W = level_w(l + 1);
                localparam int IN_N = level_n(l);
                localparam int OUT_N = level_n(l + 1);
                localparam int SHIFT = ROW_STEP << l; // gap between paired inputs.

                logic [IN_W-1:0]  src [IN_N];  // this level's inputs.
                logic [OUT_W-1:0] node [OUT_N]; // this level's registered sums.

                for (genvar s = 0; s < IN_N; s++) begin : g_src
                        if (l == 0) begin : g_first
                                assign src[s] = rows[s*ROW_W +: ROW_W];
                        end else begin : g_next
                                assign src[s] = g_lvl[l-1].node[s]; // previous level.
                        end
                end

                for (genvar k = 0; k < OUT_N; k++) begin : g_node
                        logic [OUT_W-1:0] sum_q;

                        if (2 * k + 1 < IN_N) begin : g_pair
                                // node k keeps the weight of input 2k.
                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n) begin
                                                sum_q <= '0;
                                        end else begin
                                                sum_q <= OUT_W'(src[2*k])
                                                        + (OUT_W'(src[2*k+1]) << SHIFT);
                                        end
                                end
                        end else begin : g_odd
                                // lone input, just delayed to stay aligned.
                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n) begin
                                                sum_q <= '0;
                                        end else begin
                                                sum_q <= OUT_W'(src[2*k]);
                                        end
                                end
                        end

                        assign node[k] = sum_q;
                end
        end

        // last level holds a single node, the full product.
        assign product = PROD_W'(g_lvl[LEVELS-1].node[0]);

endmodule

/* row_accumulator.sv */
`timescale 1ns/1ps

module row_accumulator #(
        parameter int OP_WIDTH = mul_geom_pkg::OP_WIDTH, // operand width.
        parameter int X_LIMB_W = mul_geom_pkg::X_LIMB_W, // x limb width.
        parameter int Y_LIMB_W = mul_geom_pkg::Y_LIMB_W, // y limb width.
        localparam int X_LIMBS = (OP_WIDTH + X_LIMB_W - 1) / X_LIMB_W,
        localparam int Y_LIMBS = (OP_WIDTH + Y_LIMB_W - 1) / Y_LIMB_W,
        localparam int PP_W = X_LIMB_W + Y_LIMB_W,
        localparam int ROW_W = OP_WIDTH + X_LIMB_W + mul_geom_pkg::ROW_GUARD
) (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic [X_LIMBS*Y_LIMBS*PP_W-1:0] pp,  // limb products from the array.
        output logic [X_LIMBS*ROW_W-1:0]        rows // row i weighs i*X_LIMB_W.
);

        // each row is x_i * y, built from the 16 column products of x_i.
        for (genvar i = 0; i < X_LIMBS; i++) begin : g_row
                logic [ROW_W-1:0] sum_c; // weighted sum, combinational.
                logic [ROW_W-1:0] sum_q; // registered row.

                always_comb begin
                        sum_c = '0;
                        for (int j = 0; j < Y_LIMBS; j++) begin
                                // column j sits j*Y_LIMB_W bits up.
                                sum_c = sum_c
                                        + (ROW_W'(pp[(i*Y_LIMBS+j)*PP_W +: PP_W])
                                        << (j * Y_LIMB_W));
                        end
                end

                // true sum stays below 2^(OP_WIDTH+X_LIMB_W), top bits idle.
                always_ff @(posedge clk or negedge rst_n) begin
                        if (!rst_n) begin
                                sum_q <= '0;
                        end else begin
                                sum_q <= sum_c;
                        end
                end

                // row weight is applied later, in the tree.
                assign rows[i*ROW_W +: ROW_W] = sum_q;
        end

endmodule

/* wide_mul_cases.svh */
`ifndef WIDE_MUL_CASES_SVH
`define WIDE_MUL_CASES_SVH

localparam int N_CASES = 31; // directed entries applied back to back.

logic [mul_geom_pkg::OP_WIDTH-1:0] case_x [N_CASES]; // multiplicand column.
logic [mul_geom_pkg::OP_WIDTH-1:0] case_y [N_CASES]; // multiplier column.
logic [mul_geom_pkg::PROD_W-1:0]   case_p [N_CASES]; // expected product column.

// single set bit at position n that wraps to zero at n = 512.
function automatic logic [mul_geom_pkg::PROD_W-1:0] pow2(input int n);
        return {{(mul_geom_pkg::PROD_W-1){1'b0}}, 1'b1} << n;
endfunction

task automatic set_case(input int i, input logic [mul_geom_pkg::PROD_W-1:0] a,
                        input logic [mul_geom_pkg::PROD_W-1:0] b,
                        input logic [mul_geom_pkg::PROD_W-1:0] p);
        case_x[i] = a[mul_geom_pkg::OP_WIDTH-1:0];
        case_y[i] = b[mul_geom_pkg::OP_WIDTH-1:0];
        case_p[i] = p;
endtask

task automatic fill_cases();
        set_case(0, 0, pow2(256) - 1, 0); // zero times all ones.
        set_case(1, pow2(256) - 1, 0, 0);
        set_case(2, 1, pow2(256) - 1, pow2(256) - 1); // one times y.
        set_case(3, pow2(256) - 1, 1, pow2(256) - 1);
        set_case(4, pow2(256) - 1, pow2(256) - 1, {{255{1'b1}}, 256'h0, 1'b1}); // 2^512-2^257+1.
        set_case(5, pow2(24), pow2(16), pow2(40)); // first x and y limb boundaries.
        set_case(6, pow2(23), pow2(15), pow2(38)); // top bits of limb 0.
        set_case(7, pow2(240), pow2(240), pow2(480)); // last x limb, last y limb.
        set_case(8, pow2(255), pow2(255), pow2(510)); // msb times msb.
        set_case(9, pow2(216), pow2(16), pow2(232)); // row 9, column 1.
        set_case(10, pow2(24) - 1, pow2(256) - 1, pow2(280) - pow2(256) - pow2(24) + 1);
        set_case(11, pow2(256) - 1, pow2(16) - 1, pow2(272) - pow2(256) - pow2(16) + 1);
        set_case(12, pow2(240) - pow2(216), pow2(256) - pow2(240),
                 pow2(496) - pow2(480) - pow2(472) + pow2(456)); // limb 9 by limb 15.
        // short top x limb with the expected value written mod 2^512.
        set_case(13, pow2(256) - pow2(240), pow2(256) - 1, pow2(240) - pow2(256) - pow2(496));
        set_case(14, pow2(256) - 1, pow2(128), pow2(384) - pow2(128)); // carries through all rows.
        // a single bit at every x limb and every y limb boundary.
        for (int k = 0; k < 16; k++) begin
                set_case(15 + k, pow2(24 * (k % 11)), pow2(16 * k),
                         pow2(24 * (k % 11) + 16 * k));
        end
endtask

`endif

/* wide_mul_tb.sv */
`timescale 1ns/1ps

module wide_mul_tb;

        `include "wide_mul_cases.svh"

        localparam int OP_W = mul_geom_pkg::OP_WIDTH;
        localparam int PROD_W = mul_geom_pkg::PROD_W;
        localparam int LAT = mul_pipe_pkg::LATENCY; // clocks from drive to check.
        localparam int RST_CYCLES = 5;
        localparam int N_RANDOM = 200;
        localparam int CYCLE_LIMIT = RST_CYCLES + N_CASES + N_RANDOM + LAT + 20;

        logic              clk;
        logic              rst_n;
        logic [OP_W-1:0]   x;
        logic [OP_W-1:0]   y;
        logic [PROD_W-1:0] product;

        logic [PROD_W-1:0] exp_q [$]; // one entry per driven cycle.
        logic [PROD_W-1:0] ra;        // random operands with the upper half zero.
        logic [PROD_W-1:0] rb;
        int                seed;
        int                cycles = 0;
        int                checks = 0;
        int                errors = 0;
        int                tests_pass = 0;
        int                tests_fail = 0;
        int                err_mark;

        wide_mul_top #(
                .OP_WIDTH (mul_geom_pkg::OP_WIDTH),
                .X_LIMB_W (mul_geom_pkg::X_LIMB_W),
                .Y_LIMB_W (mul_geom_pkg::Y_LIMB_W)
        ) wide_mul_top_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .x       (x),
                .y       (y),
                .product (product)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk; // 20 ns period.
        end

        // hard stop if the run overstays.
        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
                        $display("=== FAIL ===");
                        $finish;
                end
        end

        task automatic check(input string name, input logic [PROD_W-1:0] got,
                             input logic [PROD_W-1:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Fail %s: got %h expected %h", name, got, exp);
                end
        endtask

        // compare the oldest entry and drive the next pair.
        task automatic step(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b,
                            input logic [PROD_W-1:0] p);
                @(negedge clk);
                if (exp_q.size() >= LAT) begin
                        check("product", product, exp_q.pop_front()); // exactly LAT old.
                end
                x = a;
                y = b;
                exp_q.push_back(p);
        endtask

        // zero inputs until the pipe has emptied.
        task automatic flush();
                repeat (LAT) step('0, '0, '0);
        endtask

        task automatic draw_operand(output logic [PROD_W-1:0] v);
                v = '0;
                for (int w = 0; w < OP_W / 32; w++) begin
                        v[w*32 +: 32] = $random(seed);
                end
        endtask

        task automatic close_test(input string name, input int err_before);
                if (errors == err_before) begin
                        tests_pass++;
                        $display("test %s passed", name);
                end else begin
                        tests_fail++;
                        $display("test %s failed, %0d mismatches", name, errors - err_before);
                end
        endtask

        initial begin
                seed = 25458;
                rst_n = 1'b0;
                x = '1; // nonzero pair must not leak through reset.
                y = '1;
                fill_cases();

                // product reads zero in reset and for LAT clocks after it.
                err_mark = errors;
                repeat (RST_CYCLES) begin
                        @(negedge clk);
                        check("product", product, '0);
                end
                rst_n = 1'b1;
                x = '0;
                y = '0;
                repeat (LAT) exp_q.push_back('0); // pipe holds zeros out of reset.
                flush();
                close_test("reset_zero", err_mark);

                // directed table with one entry per clock.
                err_mark = errors;
                for (int i = 0; i < N_CASES; i++) begin
                        step(case_x[i], case_y[i], case_p[i]);
                end
                flush();
                close_test("directed_table", err_mark);

                // random stream against a native wide multiply.
                err_mark = errors;
                for (int i = 0; i < N_RANDOM; i++) begin
                        draw_operand(ra);
                        draw_operand(rb);
                        step(ra[OP_W-1:0], rb[OP_W-1:0], ra * rb);
                end
                flush();
                close_test("random_stream", err_mark);

                $display("tests passed %0d failed %0d, checks %0d, mismatches %0d",
                         tests_pass, tests_fail, checks, errors);
                if (tests_fail == 0 && errors == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

/* wide_mul_top.sv */
`timescale 1ns/1ps

module wide_mul_top #(
        parameter int OP_WIDTH = mul_geom_pkg::OP_WIDTH, // operand width.
        parameter int X_LIMB_W = mul_geom_pkg::X_LIMB_W, // x limb width.
        parameter int Y_LIMB_W = mul_geom_pkg::Y_LIMB_W, // y limb width.
        localparam int X_LIMBS = (OP_WIDTH + X_LIMB_W - 1) / X_LIMB_W,
        localparam int Y_LIMBS = (OP_WIDTH + Y_LIMB_W - 1) / Y_LIMB_W,
        localparam int PP_W = X_LIMB_W + Y_LIMB_W,
        localparam int ROW_W = OP_WIDTH + X_LIMB_W + mul_geom_pkg::ROW_GUARD,
        localparam int PROD_W = 2 * OP_WIDTH
) (
        input  logic                clk,
        input  logic                rst_n,
        input  logic [OP_WIDTH-1:0] x,      // new pair every clock.
        input  logic [OP_WIDTH-1:0] y,
        output logic [PROD_W-1:0]   product // x*y, a fixed latency later.
);

        logic [X_LIMBS*Y_LIMBS*PP_W-1:0] pp;   // stage 1 out, limb products.
        logic [X_LIMBS*ROW_W-1:0]        rows; // stage 2 out, one row per x limb.

        partial_product_array #(
                .OP_WIDTH (OP_WIDTH),
                .X_LIMB_W (X_LIMB_W),
                .Y_LIMB_W (Y_LIMB_W)
        ) partial_product_array_inst (
                .clk   (clk),
                .rst_n (rst_n),
                .x     (x),
                .y     (y),
                .pp    (pp)
        );

        row_accumulator #(
                .OP_WIDTH (OP_WIDTH),
                .X_LIMB_W (X_LIMB_W),
                .Y_LIMB_W (Y_LIMB_W)
        ) row_accumulator_inst (
                .clk   (clk),
                .rst_n (rst_n),
                .pp    (pp),
                .rows  (rows)
        );

        // rows step by one x limb.
        reduction_tree #(
                .N_ROWS   (X_LIMBS),
                .ROW_STEP (X_LIMB_W),
                .ROW_W    (ROW_W),
                .PROD_W   (PROD_W)
        ) reduction_tree_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .rows    (rows),
                .product (product)
        );

endmodule
